//--- common/decode_pkg.sv
// ================================================
// Decode stage package
// Shared types, encodings and packed structs for
// the RV32I decode stage and its testbench
// ================================================

package decode_pkg;

    // Basic datapath types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcode, instruction bits 6 down to 2
    typedef enum logic [4:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    // Immediate layout of an instruction
    typedef enum logic [2:0] {
        INSTR_FORMAT_BAD = 3'b000,
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J
    } instr_format_e;

    // ALU operations seen by execute
    typedef enum logic [3:0] {
        ALU_OP_ADD = 4'h0,
        ALU_OP_SUB,
        ALU_OP_SLL,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_XOR,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_OR,
        ALU_OP_AND
    } alu_op_e;

    // Operand selects
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1 = 2'b00,
        ALU_OP1_SRC_PC,
        ALU_OP1_SRC_ZERO
    } alu_op1_src_e;

    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS2 = 2'b00,
        ALU_OP2_SRC_IMM,
        ALU_OP2_SRC_FOUR
    } alu_op2_src_e;

    // Writeback source for rd
    typedef enum logic {
        RD_SRC_ALU = 1'b0,
        RD_SRC_MEM = 1'b1
    } rd_src_e;

    typedef enum logic [1:0] {
        MEM_OP_NONE = 2'b00,
        MEM_OP_LOAD,
        MEM_OP_STORE
    } mem_op_e;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'b00,
        MEM_SIZE_HALF = 2'b01,
        MEM_SIZE_WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        BRANCH_NONE = 2'b00,
        BRANCH_COND,
        BRANCH_JAL,
        BRANCH_JALR
    } branch_e;

    // Same encoding as the branch funct3
    typedef enum logic [2:0] {
        CMP_OP_EQ  = 3'b000,
        CMP_OP_NE  = 3'b001,
        CMP_OP_LT  = 3'b100,
        CMP_OP_GE  = 3'b101,
        CMP_OP_LTU = 3'b110,
        CMP_OP_GEU = 3'b111
    } cmp_op_e;

    // Control bundle for execute and later stages
    typedef struct packed {
        logic         illegal;
        rd_src_e      rd_src;
        logic         rd_we;
        alu_op1_src_e alu_op1_src;
        alu_op2_src_e alu_op2_src;
        alu_op_e      alu_op;
        mem_op_e      mem_op;
        logic         mem_signed;
        mem_size_e    mem_size;
        branch_e      branch;
        cmp_op_e      cmp_op;
    } ctrl_t;

    // Packet from fetch
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    // Packet toward execute
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd_idx;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        word_t    immediate;
        ctrl_t    ctrl;
    } decode_pkt_t;

endpackage

//--- rtl/stage_reg.sv
// ================================================
// Pipeline stage register
// Valid bit with stall hold and flush clear, plus
// a payload of any packed type
// ================================================

`timescale 1ns/1ps

module stage_reg #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  PAYLOAD_T in_data,
    output logic     out_valid,
    output PAYLOAD_T out_data
);

    // Flush wins over the stall hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // Payload only follows the stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

//--- decode/imm_gen.sv
// ================================================
// Immediate generator
// Picks the instruction format from the opcode and
// builds the sign-extended immediate
// ================================================

`timescale 1ns/1ps

module imm_gen
    import decode_pkg::*;
(
    input  word_t instr,
    output word_t imm
);

    opcode_e       opcode;
    instr_format_e instr_format;

    assign opcode = opcode_e'(instr[6:2]);

    // Unsupported opcodes map to BAD
    always_comb begin
        case (opcode)
            OPCODE_OP:                 instr_format = INSTR_FORMAT_R;
            OPCODE_LOAD, OPCODE_OP_IMM,
            OPCODE_JALR:               instr_format = INSTR_FORMAT_I;
            OPCODE_STORE:              instr_format = INSTR_FORMAT_S;
            OPCODE_BRANCH:             instr_format = INSTR_FORMAT_B;
            OPCODE_AUIPC, OPCODE_LUI:  instr_format = INSTR_FORMAT_U;
            OPCODE_JAL:                instr_format = INSTR_FORMAT_J;
            default:                   instr_format = INSTR_FORMAT_BAD;
        endcase
    end

    // Sign bit is always instr[31]
    always_comb begin
        case (instr_format)
            INSTR_FORMAT_I: imm = {{20{instr[31]}}, instr[31:20]};
            INSTR_FORMAT_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offsets are in halfwords
            INSTR_FORMAT_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            // Low 12 bits are zero
            INSTR_FORMAT_U: imm = {instr[31:12], 12'h000};
            INSTR_FORMAT_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            // R and BAD have no immediate
            default:        imm = '0;
        endcase
    end

endmodule

//--- decode/ctrl_gen.sv
// ================================================
// Control generator
// Decodes opcode and function fields into the
// control bundle and flags illegal instructions
// ================================================

`timescale 1ns/1ps

module ctrl_gen
    import decode_pkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       rd_is_x0;
    logic       low_bits_ok;
    alu_op_e    arith_op;

    assign opcode      = opcode_e'(instr[6:2]);
    assign funct3      = instr[14:12];
    assign funct7_b5   = instr[30];
    // No write enable for x0 so hazard logic never sees it
    assign rd_is_x0    = (instr[11:7] == 5'd0);
    // Only 32-bit encodings are supported
    assign low_bits_ok = (instr[1:0] == 2'b11);

    // Shared funct3 map of OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  arith_op = ALU_OP_ADD;
            3'b001:  arith_op = ALU_OP_SLL;
            3'b010:  arith_op = ALU_OP_SLT;
            3'b011:  arith_op = ALU_OP_SLTU;
            3'b100:  arith_op = ALU_OP_XOR;
            3'b101:  arith_op = funct7_b5 ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  arith_op = ALU_OP_OR;
            default: arith_op = ALU_OP_AND;
        endcase
    end

    always_comb begin
        // Zero is RS1, RS2, ADD, no memory and no branch
        ctrl = '0;
        case (opcode)
            OPCODE_OP: begin
                ctrl.rd_we       = !rd_is_x0;
                ctrl.alu_op2_src = ALU_OP2_SRC_RS2;
                // SUB only exists for register operands
                if (funct3 == 3'b000 && funct7_b5) begin
                    ctrl.alu_op = ALU_OP_SUB;
                end else begin
                    ctrl.alu_op = arith_op;
                end
            end
            OPCODE_OP_IMM: begin
                ctrl.rd_we       = !rd_is_x0;
                ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
                ctrl.alu_op      = arith_op;
            end
            // Address is rs1 plus immediate
            OPCODE_LOAD: begin
                ctrl.rd_src      = RD_SRC_MEM;
                ctrl.rd_we       = !rd_is_x0;
                ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
                ctrl.mem_op      = MEM_OP_LOAD;
                ctrl.mem_signed  = !funct3[2];
                ctrl.mem_size    = mem_size_e'(funct3[1:0]);
            end
            OPCODE_STORE: begin
                ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
                ctrl.mem_op      = MEM_OP_STORE;
                ctrl.mem_size    = mem_size_e'(funct3[1:0]);
            end
            // Compare of rs1 and rs2 in execute
            OPCODE_BRANCH: begin
                ctrl.branch = BRANCH_COND;
                ctrl.cmp_op = cmp_op_e'(funct3);
            end
            // Link value is pc + 4
            OPCODE_JAL: begin
                ctrl.rd_we       = !rd_is_x0;
                ctrl.alu_op1_src = ALU_OP1_SRC_PC;
                ctrl.alu_op2_src = ALU_OP2_SRC_FOUR;
                ctrl.branch      = BRANCH_JAL;
            end
            OPCODE_JALR: begin
                ctrl.rd_we       = !rd_is_x0;
                ctrl.alu_op1_src = ALU_OP1_SRC_PC;
                ctrl.alu_op2_src = ALU_OP2_SRC_FOUR;
                ctrl.branch      = BRANCH_JALR;
            end
            OPCODE_LUI: begin
                ctrl.rd_we       = !rd_is_x0;
                ctrl.alu_op1_src = ALU_OP1_SRC_ZERO;
                ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
            end
            OPCODE_AUIPC: begin
                ctrl.rd_we       = !rd_is_x0;
                ctrl.alu_op1_src = ALU_OP1_SRC_PC;
                ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
            end
            // AMO, FENCE, SYSTEM and unknown opcodes
            default: ctrl.illegal = 1'b1;
        endcase

        // Compressed or reserved encodings
        if (!low_bits_ok) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

//--- decode/decode_stage.sv
// ================================================
// RV32I decode stage
// Input register, immediate and control decode,
// then an output register toward execute
// ================================================

`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic        in_valid,
    input  fetch_pkt_t  in,
    output logic        out_valid,
    output decode_pkt_t out
);

    logic        dec_valid;
    fetch_pkt_t  dec_in;
    word_t       imm;
    ctrl_t       ctrl;
    decode_pkt_t dec_out;

    // Captures the fetch packet
    stage_reg #(.PAYLOAD_T(fetch_pkt_t)) u_in_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (in_valid),
        .in_data  (in),
        .out_valid(dec_valid),
        .out_data (dec_in)
    );

    imm_gen u_imm_gen (
        .instr(dec_in.instr),
        .imm  (imm)
    );

    ctrl_gen u_ctrl_gen (
        .instr(dec_in.instr),
        .ctrl (ctrl)
    );

    // Register indexes come straight from the fixed RV32I fields
    assign dec_out = '{
        pc:        dec_in.pc,
        rd_idx:    dec_in.instr[11:7],
        rs1_idx:   dec_in.instr[19:15],
        rs2_idx:   dec_in.instr[24:20],
        immediate: imm,
        ctrl:      ctrl
    };

    // Presents the decoded packet to execute
    stage_reg #(.PAYLOAD_T(decode_pkt_t)) u_out_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (dec_valid),
        .in_data  (dec_out),
        .out_valid(out_valid),
        .out_data (out)
    );

endmodule

//--- testbench/decode_checker.sv
// ================================================
// Decode stage checker
// Protocol assertions on the outputs of the
// decode stage, bound into decode_stage
// ================================================

`timescale 1ns/1ps

module decode_checker
    import decode_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        stall,
    input logic        flush,
    input logic        out_valid,
    input decode_pkt_t out
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Nothing comes out of a reset edge
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after a reset edge");
        end

    // Stall holds both the valid and the payload
    stall_holds_output: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(out_valid) && $stable(out))
        else begin
            fail_count++;
            $error("output changed across a stalled edge");
        end

    // Flush drops everything in flight
    flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after a flush");
        end

    // x0 never gets a write enable
    no_write_to_x0: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !out.ctrl.rd_we || out.rd_idx != 5'd0)
        else begin
            fail_count++;
            $error("rd_we set with rd_idx zero");
        end

    no_unknown_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out))
        else begin
            fail_count++;
            $error("unknown bits in a valid output packet");
        end

endmodule

//--- testbench/tb_decode.sv
// ================================================
// Decode stage testbench
// Random RV32I stimulus, reference decode model and
// an in-order scoreboard on the output packets
// ================================================

`timescale 1ns/1ps

module tb_decode
    import decode_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    logic        in_valid;
    fetch_pkt_t  in;
    logic        out_valid;
    decode_pkt_t out;

    integer      seed = 32'ha38756dd;
    decode_pkt_t exp_q[$];
    word_t       next_pc;
    logic        last_stall;
    int          errors;
    int          tests_run;
    int          tests_failed;

    // Supported opcodes other than OP and OP-IMM
    opcode_e    other_ops[7] = '{OPCODE_LOAD, OPCODE_STORE, OPCODE_BRANCH, OPCODE_JAL,
                                 OPCODE_JALR, OPCODE_LUI, OPCODE_AUIPC};
    // Dropped or unknown major opcodes
    logic [4:0] bad_ops[6] = '{OPCODE_MISC_MEM, OPCODE_AMO, OPCODE_SYSTEM,
                               5'b11111, 5'b00010, 5'b10110};

    decode_stage u_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (in_valid),
        .in       (in),
        .out_valid(out_valid),
        .out      (out)
    );

    bind decode_stage decode_checker u_decode_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .out_valid(out_valid),
        .out      (out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int total_errors();
        return errors + int'(u_decode_stage.u_decode_checker.fail_count);
    endfunction

    task automatic flag_error(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        errors++;
    endtask

    // ALU op from the RV32I funct3 table
    function automatic alu_op_e expected_alu_op(logic [2:0] f3, logic b30, logic is_reg);
        case (f3)
            3'd0:    return (is_reg && b30) ? ALU_OP_SUB : ALU_OP_ADD;
            3'd1:    return ALU_OP_SLL;
            3'd2:    return ALU_OP_SLT;
            3'd3:    return ALU_OP_SLTU;
            3'd4:    return ALU_OP_XOR;
            3'd5:    return b30 ? ALU_OP_SRA : ALU_OP_SRL;
            3'd6:    return ALU_OP_OR;
            default: return ALU_OP_AND;
        endcase
    endfunction

    // Expected output packet for one fetch packet
    function automatic decode_pkt_t ref_decode(word_t pc, word_t instr);
        decode_pkt_t p;
        logic [2:0]  f3;
        logic        wr;
        f3 = instr[14:12];
        wr = (instr[11:7] != 5'd0);
        p = '0;
        p.pc      = pc;
        p.rd_idx  = instr[11:7];
        p.rs1_idx = instr[19:15];
        p.rs2_idx = instr[24:20];
        // Immediates by arithmetic shift of the packed fields
        case (instr[6:2])
            OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_JALR:
                p.immediate = $signed(instr) >>> 20;
            OPCODE_STORE:
                p.immediate = $signed({instr[31:25], instr[11:7], 20'h0}) >>> 20;
            OPCODE_BRANCH:
                p.immediate = $signed({instr[31], instr[7], instr[30:25], instr[11:8],
                                       1'b0, 19'h0}) >>> 19;
            OPCODE_LUI, OPCODE_AUIPC:
                p.immediate = instr & 32'hffff_f000;
            OPCODE_JAL:
                p.immediate = $signed({instr[31], instr[19:12], instr[20], instr[30:21],
                                       1'b0, 11'h0}) >>> 11;
            default:
                p.immediate = '0;
        endcase
        if (instr[1:0] != 2'b11) begin
            p.ctrl.illegal = 1'b1;
            return p;
        end
        case (instr[6:2])
            OPCODE_OP, OPCODE_OP_IMM: begin
                p.ctrl.rd_we       = wr;
                p.ctrl.alu_op2_src = (instr[6:2] == OPCODE_OP) ? ALU_OP2_SRC_RS2
                                                               : ALU_OP2_SRC_IMM;
                p.ctrl.alu_op      = expected_alu_op(f3, instr[30], instr[6:2] == OPCODE_OP);
            end
            OPCODE_LOAD: begin
                p.ctrl.rd_src      = RD_SRC_MEM;
                p.ctrl.rd_we       = wr;
                p.ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
                p.ctrl.mem_op      = MEM_OP_LOAD;
                // LBU and LHU have funct3 bit 2 set
                p.ctrl.mem_signed  = ~f3[2];
                p.ctrl.mem_size    = mem_size_e'(f3[1:0]);
            end
            OPCODE_STORE: begin
                p.ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
                p.ctrl.mem_op      = MEM_OP_STORE;
                p.ctrl.mem_size    = mem_size_e'(f3[1:0]);
            end
            OPCODE_BRANCH: begin
                p.ctrl.branch = BRANCH_COND;
                p.ctrl.cmp_op = cmp_op_e'(f3);
            end
            OPCODE_JAL, OPCODE_JALR: begin
                p.ctrl.rd_we       = wr;
                p.ctrl.alu_op1_src = ALU_OP1_SRC_PC;
                p.ctrl.alu_op2_src = ALU_OP2_SRC_FOUR;
                p.ctrl.branch      = (instr[6:2] == OPCODE_JAL) ? BRANCH_JAL : BRANCH_JALR;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                p.ctrl.rd_we       = wr;
                p.ctrl.alu_op1_src = (instr[6:2] == OPCODE_LUI) ? ALU_OP1_SRC_ZERO
                                                                : ALU_OP1_SRC_PC;
                p.ctrl.alu_op2_src = ALU_OP2_SRC_IMM;
            end
            default: p.ctrl.illegal = 1'b1;
        endcase
        return p;
    endfunction

    // Random word forced onto a legal encoding of op
    function automatic word_t make_instr(opcode_e op);
        word_t w;
        word_t r;
        w = $random(seed);
        r = $random(seed);
        w[6:0] = {op, 2'b11};
        // About a quarter go to x0
        if (r[1:0] == 2'b00)
            w[11:7] = 5'd0;
        case (op)
            OPCODE_OP:
                w[31:25] = {1'b0, w[30], 5'b00000};
            OPCODE_OP_IMM:
                if (w[13:12] == 2'b01)
                    w[31:25] = {1'b0, w[30], 5'b00000};
            OPCODE_LOAD: begin
                if (w[13:12] == 2'b11)
                    w[13:12] = 2'b10;
                if (w[14] && w[13])
                    w[14] = 1'b0;
            end
            OPCODE_STORE: begin
                w[14] = 1'b0;
                if (w[13:12] == 2'b11)
                    w[12] = 1'b0;
            end
            OPCODE_BRANCH:
                if (w[14:13] == 2'b01)
                    w[13] = 1'b0;
            OPCODE_JALR:
                w[14:12] = 3'b000;
            default: ;
        endcase
        return w;
    endfunction

    // Drives one packet and returns 1 ns after the capturing edge
    task automatic send(word_t instr);
        in_valid = 1'b1;
        in.pc    = next_pc;
        in.instr = instr;
        exp_q.push_back(ref_decode(next_pc, instr));
        next_pc  = next_pc + 32'd4;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected packets never left the DUT", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic end_test(string name, int errors_before);
        tests_run++;
        if (total_errors() == errors_before) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL, %0d errors", name, total_errors() - errors_before);
        end
    endtask

    // A packet is new when the last edge was not stalled
    always @(negedge clk) begin
        decode_pkt_t expected;
        if (out_valid && !last_stall) begin
            assert (exp_q.size() > 0)
                else flag_error($sformatf("unexpected packet, pc %h", out.pc));
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (out == expected)
                    else flag_error($sformatf("pc %h got %h expected %h",
                                              expected.pc, out, expected));
            end
        end
        last_stall = stall;
    end

    initial begin
        int          e0;
        word_t       w;
        decode_pkt_t held;
        logic        held_valid;
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in           = '0;
        next_pc      = 32'h0000_1000;
        last_stall   = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        // Reset, latency and order
        e0 = total_errors();
        repeat (8) begin
            @(posedge clk);
            #1;
            assert (!out_valid) else flag_error("out_valid high during reset");
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            assert (!out_valid) else flag_error("out_valid high with nothing sent");
        end
        send(make_instr(OPCODE_OP_IMM));
        assert (!out_valid) else flag_error("packet out one edge early");
        @(posedge clk);
        #1;
        assert (out_valid) else flag_error("packet not out after two edges");
        for (int i = 0; i < 6; i++) begin
            send(make_instr(OPCODE_OP));
        end
        wait_drain();
        end_test("reset_and_latency", e0);

        e0 = total_errors();
        for (int i = 0; i < 60; i++) begin
            send(make_instr(i[0] ? OPCODE_OP : OPCODE_OP_IMM));
        end
        wait_drain();
        end_test("alu_ops", e0);

        e0 = total_errors();
        for (int i = 0; i < 84; i++) begin
            send(make_instr(other_ops[i % 7]));
        end
        wait_drain();
        end_test("mem_branch_jump_upper", e0);

        // Bad opcodes first, then good opcodes with bad low bits
        e0 = total_errors();
        for (int i = 0; i < 30; i++) begin
            w = $random(seed);
            if (i < 15) begin
                w[6:0] = {bad_ops[i % 6], 2'b11};
            end else begin
                w[6:2] = other_ops[i % 7];
                if (w[1:0] == 2'b11)
                    w[1:0] = 2'b01;
            end
            send(w);
        end
        wait_drain();
        end_test("illegal", e0);

        // Two items in flight while stalled
        e0 = total_errors();
        send(make_instr(OPCODE_LOAD));
        send(make_instr(OPCODE_JAL));
        stall      = 1'b1;
        held       = out;
        held_valid = out_valid;
        repeat (5) begin
            @(posedge clk);
            #1;
            assert (out_valid == held_valid && out == held)
                else flag_error("output moved while stalled");
        end
        stall = 1'b0;
        wait_drain();
        end_test("stall", e0);

        // Flush on the edge that captures the second item
        e0 = total_errors();
        send(make_instr(OPCODE_AUIPC));
        flush = 1'b1;
        send(make_instr(OPCODE_LUI));
        flush = 1'b0;
        assert (!out_valid) else flag_error("out_valid high after flush");
        assert (exp_q.size() == 2) else flag_error("flushed items left the DUT");
        exp_q.delete();
        send(make_instr(OPCODE_BRANCH));
        wait_drain();
        end_test("flush", e0);

        // Room for a late duplicate to show up
        repeat (4) @(posedge clk);
        $display("Tests: %0d run, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/decode_pkg.sv
rtl/stage_reg.sv
decode/imm_gen.sv
decode/ctrl_gen.sv
decode/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run the testbench, fail on a failed run"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_decode -f vlog.f
	./obj_dir/Vtb_decode > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
